/* all.f */
+incdir+hw
hw/tcb_pkg.sv
hw/tcb_if.sv
hw/tcb_riscv_align.sv
hw/tcb_arbiter.sv
hw/tcb_mem.sv
hw/tcb_mem_top.sv
tb/tcb_mem_tb.sv

/* Makefile */
# Verilator build and run for the TCB scratch memory

VERILATOR ?= verilator
TOP       ?= tcb_mem_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hw/*.sv hw/*.svh tb/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^TB PASSED$$" $(LOG); then \
	  echo "result: pass"; \
	else \
	  echo "result: fail"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tcb_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcb_defines.svh"

module tcb_mem_tb;
  import tcb_pkg::*;

  localparam int N_TBL  = 32;
  localparam int N_FILL = 64;
  localparam int N_ARB  = 24;
  localparam int N_RND  = 200;
  localparam int MW     = $clog2(4 * `TCB_MEM_WORDS);
  // 4 cycles per request plus reset
  localparam int WD_CYC = (N_TBL + N_FILL + N_ARB + N_RND) * 4 + 8;

  localparam logic       PA   = 1'b0;
  localparam logic       PB   = 1'b1;
  localparam logic [3:0] SZ_B = 4'(TCB_SIZ_BYTE);
  localparam logic [3:0] SZ_H = 4'(TCB_SIZ_HALF);
  localparam logic [3:0] SZ_W = 4'(TCB_SIZ_WORD);

  // one request where sel is siz on port a and ben on port b
  typedef struct packed {
    logic               port;
    logic               wen;
    logic [`TCB_AW-1:0] adr;
    logic [3:0]         sel;
    logic               uns;
    logic [31:0]        wdt;
    logic [31:0]        exp_rdt;
    logic               exp_sts;
    logic               chk_rdt;
    logic               use_model;
  } req_t;

  logic                 tcb;
  logic                 rst;
  logic                 a_vld;
  logic                 a_rdy;
  logic                 a_wen;
  logic [`TCB_AW-1:0]   a_adr;
  tcb_siz_t             a_siz;
  logic                 a_uns;
  logic [`TCB_DW-1:0]   a_wdt;
  logic [`TCB_DW-1:0]   a_rdt;
  logic                 a_sts;
  logic                 b_vld;
  logic                 b_rdy;
  logic                 b_wen;
  logic [`TCB_AW-1:0]   b_adr;
  logic [`TCB_DW/8-1:0] b_ben;
  logic [`TCB_DW-1:0]   b_wdt;
  logic [`TCB_DW-1:0]   b_rdt;
  logic                 b_sts;

  // byte reference model
  logic [7:0]  model [0:4*`TCB_MEM_WORDS-1];
  req_t        tbl [0:N_TBL-1];
  req_t        pend [2][$];
  logic [31:0] seed;
  // 1 means port b was served last
  logic        last_gnt;

  tcb_mem_top dut_i (
    .tcb   (tcb),
    .rst   (rst),
    .a_vld (a_vld),
    .a_rdy (a_rdy),
    .a_wen (a_wen),
    .a_adr (a_adr),
    .a_siz (a_siz),
    .a_uns (a_uns),
    .a_wdt (a_wdt),
    .a_rdt (a_rdt),
    .a_sts (a_sts),
    .b_vld (b_vld),
    .b_rdy (b_rdy),
    .b_wen (b_wen),
    .b_adr (b_adr),
    .b_ben (b_ben),
    .b_wdt (b_wdt),
    .b_rdt (b_rdt),
    .b_sts (b_sts)
  );

  always #4 tcb = ~tcb;

  ////////////////////
  // helpers
  ////////////////////

  function automatic req_t mk(logic port, logic wen, logic [`TCB_AW-1:0] adr,
                              logic [3:0] sel, logic uns, logic [31:0] wdt,
                              logic [31:0] rdt, logic sts);
    req_t r;
    r.port      = port;
    r.wen       = wen;
    r.adr       = adr;
    r.sel       = sel;
    r.uns       = uns;
    r.wdt       = wdt;
    r.exp_rdt   = rdt;
    r.exp_sts   = sts;
    r.chk_rdt   = !wen && !sts;
    r.use_model = 1'b0;
    return r;
  endfunction

  // expected values filled in from the model at transfer time
  function automatic req_t model_req(logic port, logic wen, logic [`TCB_AW-1:0] adr,
                                     logic [3:0] sel, logic uns, logic [31:0] wdt);
    req_t r;
    r           = mk(port, wen, adr, sel, uns, wdt, 32'h0, 1'b0);
    r.use_model = 1'b1;
    return r;
  endfunction

  // both halves depend on the whole address
  function automatic logic [31:0] fill_word(logic [15:0] adr);
    return {adr ^ 16'hc3a5, adr + 16'h1357};
  endfunction

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // little endian with the lowest address in bits 7:0
  function automatic logic [31:0] model_load(req_t r);
    logic [MW-1:0] ix;
    logic [31:0]   w;
    ix = MW'(r.adr);
    if (r.port == PB) begin
      ix[1:0] = 2'b00;
    end
    w = {model[ix + MW'(3)], model[ix + MW'(2)], model[ix + MW'(1)], model[ix]};
    if (r.port == PB || r.sel[1:0] == TCB_SIZ_WORD) begin
      return w;
    end
    if (r.sel[1:0] == TCB_SIZ_HALF) begin
      return {{16{w[15] & ~r.uns}}, w[15:0]};
    end
    return {{24{w[7] & ~r.uns}}, w[7:0]};
  endfunction

  function automatic void model_store(req_t r);
    logic [MW-1:0] ix;
    int            n;
    ix = MW'(r.adr);
    if (r.port == PB) begin
      ix[1:0] = 2'b00;
      for (int i = 0; i < 4; i++) begin
        if (r.sel[i]) begin
          model[ix + MW'(i)] = r.wdt[8*i +: 8];
        end
      end
    end else begin
      // store data sits in the low bytes
      n = 1 << r.sel[1:0];
      for (int i = 0; i < n; i++) begin
        model[ix + MW'(i)] = r.wdt[8*i +: 8];
      end
    end
  endfunction

  // transfers are serialized so the model follows grant order
  function automatic req_t resolve(req_t r);
    req_t e;
    e = r;
    if (r.use_model) begin
      e.exp_sts = 1'b0;
      e.exp_rdt = r.wen ? 32'h0 : model_load(r);
      e.chk_rdt = !r.wen;
    end
    if (e.wen && !e.exp_sts) begin
      model_store(e);
    end
    return e;
  endfunction

  function automatic void enqueue(req_t r);
    pend[r.port].push_back(r);
  endfunction

  task automatic report_error(string what, logic [31:0] got, logic [31:0] exp);
    $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
    $display("TB FAILED");
    $fatal(1, "value check failed");
  endtask

  task automatic drive(logic p, logic busy, req_t r);
    if (p == PA) begin
      a_vld = busy;
      a_wen = r.wen;
      a_adr = r.adr;
      a_siz = r.sel[1:0];
      a_uns = r.uns;
      a_wdt = r.wdt;
    end else begin
      b_vld = busy;
      b_wen = r.wen;
      b_adr = r.adr;
      b_ben = r.sel;
      b_wdt = r.wdt;
    end
  endtask

  task automatic check_rsp(logic p, req_t r);
    logic [31:0] rdt;
    logic        sts;
    string       tag;
    rdt = (p == PA) ? a_rdt : b_rdt;
    sts = (p == PA) ? a_sts : b_sts;
    tag = $sformatf("port %s adr %h", (p == PA) ? "a" : "b", r.adr);
    assert (sts === r.exp_sts)
      else report_error({tag, " sts"}, 32'(sts), 32'(r.exp_sts));
    if (r.chk_rdt) begin
      assert (rdt === r.exp_rdt)
        else report_error({tag, " rdt"}, rdt, r.exp_rdt);
    end
  endtask

  ////////////////////
  // request engine
  ////////////////////

  // drive both queue heads until every request has its response
  task automatic run_queues();
    req_t cur [2];
    req_t fly [2];
    logic busy [2];
    logic inf [2];
    logic rdy [2];
    logic exp_rdy [2];
    inf[0] = 1'b0;
    inf[1] = 1'b0;
    while (pend[0].size() != 0 || pend[1].size() != 0 || inf[0] || inf[1]) begin
      @(negedge tcb);
      // responses of the last rising edge
      for (int p = 0; p < 2; p++) begin
        if (inf[p]) begin
          check_rsp(p[0], fly[p]);
          inf[p] = 1'b0;
        end
      end
      for (int p = 0; p < 2; p++) begin
        busy[p] = pend[p].size() != 0;
        if (busy[p]) begin
          cur[p] = pend[p][0];
        end else begin
          cur[p] = '0;
        end
        drive(p[0], busy[p], cur[p]);
      end
      // grant is settled well before the edge
      #1;
      rdy[0]     = a_rdy;
      rdy[1]     = b_rdy;
      // tie goes to the port not served last
      exp_rdy[0] = busy[0] && (!busy[1] || last_gnt);
      exp_rdy[1] = busy[1] && (!busy[0] || !last_gnt);
      assert (rdy[0] === exp_rdy[0] && rdy[1] === exp_rdy[1])
        else report_error("ready pair {a_rdy, b_rdy}", {30'h0, rdy[0], rdy[1]},
                          {30'h0, exp_rdy[0], exp_rdy[1]});
      for (int p = 0; p < 2; p++) begin
        if (busy[p] && rdy[p]) begin
          fly[p]   = resolve(pend[p].pop_front());
          inf[p]   = 1'b1;
          last_gnt = p[0];
        end
      end
    end
  endtask

  ////////////////////
  // directed table
  ////////////////////

  function automatic void load_table();
    // byte enables on port b
    tbl[0]  = mk(PB, 1'b1, 16'h0040, 4'hf, 1'b0, 32'h11223344, 32'h0, 1'b0);
    tbl[1]  = mk(PB, 1'b1, 16'h0040, 4'h5, 1'b0, 32'haabbccdd, 32'h0, 1'b0);
    tbl[2]  = mk(PB, 1'b0, 16'h0040, 4'hf, 1'b0, 32'h0, 32'h11bb33dd, 1'b0);
    tbl[3]  = mk(PB, 1'b1, 16'h0040, 4'h8, 1'b0, 32'h99000000, 32'h0, 1'b0);
    tbl[4]  = mk(PB, 1'b0, 16'h0040, 4'hf, 1'b0, 32'h0, 32'h99bb33dd, 1'b0);
    // sized loads and stores with sign and zero extension
    tbl[5]  = mk(PA, 1'b1, 16'h0050, SZ_W, 1'b0, 32'h80f47f85, 32'h0, 1'b0);
    tbl[6]  = mk(PA, 1'b0, 16'h0050, SZ_B, 1'b0, 32'h0, 32'hffffff85, 1'b0);
    tbl[7]  = mk(PA, 1'b0, 16'h0050, SZ_B, 1'b1, 32'h0, 32'h00000085, 1'b0);
    tbl[8]  = mk(PA, 1'b0, 16'h0051, SZ_B, 1'b0, 32'h0, 32'h0000007f, 1'b0);
    tbl[9]  = mk(PA, 1'b0, 16'h0052, SZ_H, 1'b0, 32'h0, 32'hffff80f4, 1'b0);
    tbl[10] = mk(PA, 1'b0, 16'h0052, SZ_H, 1'b1, 32'h0, 32'h000080f4, 1'b0);
    tbl[11] = mk(PA, 1'b0, 16'h0050, SZ_W, 1'b0, 32'h0, 32'h80f47f85, 1'b0);
    tbl[12] = mk(PA, 1'b1, 16'h0053, SZ_B, 1'b0, 32'h000000aa, 32'h0, 1'b0);
    tbl[13] = mk(PA, 1'b1, 16'h0050, SZ_H, 1'b0, 32'h0000c001, 32'h0, 1'b0);
    tbl[14] = mk(PA, 1'b0, 16'h0050, SZ_W, 1'b0, 32'h0, 32'haaf4c001, 1'b0);
    tbl[15] = mk(PA, 1'b0, 16'h0051, SZ_B, 1'b0, 32'h0, 32'hffffffc0, 1'b0);
    tbl[16] = mk(PA, 1'b0, 16'h0053, SZ_B, 1'b1, 32'h0, 32'h000000aa, 1'b0);
    // one port writes and the other reads
    tbl[17] = mk(PA, 1'b1, 16'h0060, SZ_W, 1'b0, 32'h12345678, 32'h0, 1'b0);
    tbl[18] = mk(PB, 1'b0, 16'h0060, 4'hf, 1'b0, 32'h0, 32'h12345678, 1'b0);
    tbl[19] = mk(PB, 1'b1, 16'h0064, 4'hf, 1'b0, 32'hdeadbeef, 32'h0, 1'b0);
    tbl[20] = mk(PA, 1'b0, 16'h0066, SZ_H, 1'b1, 32'h0, 32'h0000dead, 1'b0);
    tbl[21] = mk(PA, 1'b0, 16'h0064, SZ_W, 1'b0, 32'h0, 32'hdeadbeef, 1'b0);
    // misaligned accesses leave memory as it was
    tbl[22] = mk(PA, 1'b1, 16'h0061, SZ_H, 1'b0, 32'h0000ffff, 32'h0, 1'b1);
    tbl[23] = mk(PA, 1'b1, 16'h0062, SZ_W, 1'b0, 32'hffffffff, 32'h0, 1'b1);
    tbl[24] = mk(PA, 1'b0, 16'h0063, SZ_H, 1'b0, 32'h0, 32'h0, 1'b1);
    tbl[25] = mk(PA, 1'b0, 16'h0060, SZ_W, 1'b0, 32'h0, 32'h12345678, 1'b0);
    // out of range addresses that would alias words 0 and 1
    tbl[26] = mk(PB, 1'b1, 16'h1000, 4'hf, 1'b0, 32'h0badf00d, 32'h0, 1'b1);
    tbl[27] = mk(PB, 1'b0, 16'h1000, 4'hf, 1'b0, 32'h0, 32'h0, 1'b1);
    tbl[28] = mk(PA, 1'b1, 16'h1004, SZ_W, 1'b0, 32'h0badf00d, 32'h0, 1'b1);
    tbl[29] = mk(PA, 1'b0, 16'hfffc, SZ_W, 1'b0, 32'h0, 32'h0, 1'b1);
    tbl[30] = mk(PB, 1'b0, 16'h0000, 4'hf, 1'b0, 32'h0, 32'hc3a51357, 1'b0);
    tbl[31] = mk(PA, 1'b0, 16'h0004, SZ_W, 1'b0, 32'h0, 32'hc3a1135b, 1'b0);
  endfunction

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    logic [31:0]        v;
    logic [`TCB_AW-1:0] adr;
    logic [1:0]         siz;
    tcb        = 1'b0;
    rst        = 1'b1;
    a_vld      = 1'b0;
    a_wen      = 1'b0;
    a_adr      = '0;
    a_siz      = TCB_SIZ_BYTE;
    a_uns      = 1'b0;
    a_wdt      = '0;
    b_vld      = 1'b0;
    b_wen      = 1'b0;
    b_adr      = '0;
    b_ben      = '0;
    b_wdt      = '0;
    seed       = 32'hce1b;
    last_gnt   = 1'b1;
    load_table();
    repeat (4) @(posedge tcb);
    @(negedge tcb);
    rst = 1'b0;

    // known contents for the low 256 bytes
    for (int i = 0; i < N_FILL; i++) begin
      adr = `TCB_AW'(4 * i);
      enqueue(mk(PB, 1'b1, adr, 4'hf, 1'b0, fill_word(adr), 32'h0, 1'b0));
    end
    run_queues();

    // one entry at a time
    for (int i = 0; i < N_TBL; i++) begin
      enqueue(tbl[i]);
      run_queues();
    end

    // both ports hold vld and reads cross over
    for (int i = 0; i < N_ARB / 4; i++) begin
      adr = `TCB_AW'(32'h80 + 4 * i);
      enqueue(model_req(PA, 1'b1, adr, SZ_W, 1'b0, next_rand()));
      enqueue(model_req(PB, 1'b1, adr + 16'h20, 4'hf, 1'b0, next_rand()));
    end
    for (int i = 0; i < N_ARB / 4; i++) begin
      adr = `TCB_AW'(32'h80 + 4 * i);
      enqueue(model_req(PA, 1'b0, adr + 16'h20, SZ_W, 1'b0, 32'h0));
      enqueue(model_req(PB, 1'b0, adr, 4'hf, 1'b0, 32'h0));
    end
    run_queues();

    // mixed traffic that is aligned and in range
    for (int i = 0; i < N_RND; i++) begin
      v   = next_rand();
      adr = {8'h00, v[15:8]};
      if (v[31] == PA) begin
        siz = 2'(v[23:16] % 8'd3);
        if (siz == TCB_SIZ_HALF) begin
          adr[0] = 1'b0;
        end
        if (siz == TCB_SIZ_WORD) begin
          adr[1:0] = 2'b00;
        end
        enqueue(model_req(PA, v[30], adr, {2'b00, siz}, v[29], next_rand()));
      end else begin
        // port b ignores the low address bits
        enqueue(model_req(PB, v[30], adr, v[27:24], 1'b0, next_rand()));
      end
    end
    run_queues();

    repeat (2) @(negedge tcb);
    $display("TB PASSED");
    $finish;
  end

  // hang guard
  initial begin
    #(WD_CYC * 8);
    $display("watchdog expired after %0d cycles, requests still pending", WD_CYC);
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

endmodule: tcb_mem_tb

`default_nettype wire

/* hw/tcb_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcb_defines.svh"

module tcb_mem_top (
  input  logic                  tcb,
  input  logic                  rst,
  // port a, risc-v load/store
  input  logic                  a_vld,
  output logic                  a_rdy,
  input  logic                  a_wen,
  input  logic [`TCB_AW-1:0]    a_adr,
  input  tcb_pkg::tcb_siz_t     a_siz,
  input  logic                  a_uns,
  input  logic [`TCB_DW-1:0]    a_wdt,
  output logic [`TCB_DW-1:0]    a_rdt,
  output logic                  a_sts,
  // port b, byte enables
  input  logic                  b_vld,
  output logic                  b_rdy,
  input  logic                  b_wen,
  input  logic [`TCB_AW-1:0]    b_adr,
  input  logic [`TCB_DW/8-1:0]  b_ben,
  input  logic [`TCB_DW-1:0]    b_wdt,
  output logic [`TCB_DW-1:0]    b_rdt,
  output logic                  b_sts
);

  tcb_if align_if ();
  tcb_if dma_if ();
  tcb_if mem_if ();

  ////////////////////
  // port a
  ////////////////////

  tcb_riscv_align align_i (
    .tcb (tcb),
    .rst (rst),
    .vld (a_vld),
    .rdy (a_rdy),
    .wen (a_wen),
    .adr (a_adr),
    .siz (a_siz),
    .uns (a_uns),
    .wdt (a_wdt),
    .rdt (a_rdt),
    .sts (a_sts),
    .mem (align_if)
  );

  ////////////////////
  // port b
  ////////////////////

  // low address bits do not matter, lanes come from ben
  assign dma_if.vld     = b_vld;
  assign dma_if.req.wen = b_wen;
  assign dma_if.req.adr = {b_adr[`TCB_AW-1:2], 2'b00};
  assign dma_if.req.ben = b_ben;
  assign dma_if.req.wdt = b_wdt;

  assign b_rdy = dma_if.rdy;
  assign b_rdt = dma_if.rsp.rdt;
  assign b_sts = dma_if.rsp.sts;

  ////////////////////
  // shared memory
  ////////////////////

  // port a is index 0
  tcb_arbiter arbiter_i (
    .tcb  (tcb),
    .rst  (rst),
    .man0 (align_if),
    .man1 (dma_if),
    .sub  (mem_if)
  );

  tcb_mem mem_i (
    .tcb (tcb),
    .rst (rst),
    .bus (mem_if)
  );

endmodule: tcb_mem_top

`default_nettype wire

/* hw/tcb_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcb_defines.svh"

module tcb_mem (
  input  logic tcb,
  input  logic rst,
  tcb_if.sub   bus
);

  localparam int unsigned IW = $clog2(`TCB_MEM_WORDS);
  localparam int unsigned BN = `TCB_DW / 8;

  // word array
  logic [`TCB_DW-1:0] mem [0:`TCB_MEM_WORDS-1];

  logic               rng;
  logic [IW-1:0]      idx;
  logic [`TCB_DW-1:0] rdt;
  logic               sts;

  ////////////////////
  // decode
  ////////////////////

  // never stalls
  assign bus.rdy = 1'b1;

  // byte address below the memory size
  assign rng = 32'(bus.req.adr) < 4 * `TCB_MEM_WORDS;
  assign idx = bus.req.adr[IW+1:2];

  ////////////////////
  // write
  ////////////////////

  // per-lane enables and no write out of range
  always_ff @(posedge tcb) begin
    if (bus.trn && bus.req.wen && rng) begin
      for (int b = 0; b < BN; b++) begin
        if (bus.req.ben[b]) begin
          mem[idx][8*b +: 8] <= bus.req.wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////
  // read
  ////////////////////

  // whole word read as the requester picks the lanes
  always_ff @(posedge tcb) begin
    if (bus.trn && !bus.req.wen && rng) begin
      rdt <= mem[idx];
    end
  end

  // error for reads and writes alike
  always_ff @(posedge tcb) begin
    if (rst) begin
      sts <= 1'b0;
    end else begin
      sts <= bus.trn & ~rng;
    end
  end

  always_comb begin
    bus.rsp = '{rdt: rdt, sts: sts};
  end

  // request fully driven while valid
  assert property (@(posedge tcb) disable iff (rst) bus.vld |-> !$isunknown(bus.req));

endmodule: tcb_mem

`default_nettype wire

/* hw/tcb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcb_defines.svh"

module tcb_arbiter (
  input  logic tcb,
  input  logic rst,
  // requesters
  tcb_if.sub   man0,
  tcb_if.sub   man1,
  // shared responder
  tcb_if.man   sub
);

  // index granted last time
  logic last;
  logic gnt0;
  logic gnt1;
  logic sel;
  // owner of each transfer in flight
  logic own [0:`TCB_DLY-1];
  logic own_rsp;

  ////////////////////
  // grant
  ////////////////////

  // the one not served last wins a tie
  assign gnt0 = man0.vld & (~man1.vld | last);
  assign gnt1 = man1.vld & (~man0.vld | ~last);
  assign sel  = gnt1;

  // request mux
  assign sub.vld = man0.vld | man1.vld;
  assign sub.req = sel ? man1.req : man0.req;

  // ready only to the winner
  assign man0.rdy = gnt0 & sub.rdy;
  assign man1.rdy = gnt1 & sub.rdy;

  // pointer starts out favoring port 0
  always_ff @(posedge tcb) begin
    if (rst) begin
      last <= 1'b1;
    end else if (sub.trn) begin
      last <= sel;
    end
  end

  ////////////////////
  // response routing
  ////////////////////

  always_ff @(posedge tcb) begin
    if (rst) begin
      for (int i = 0; i < `TCB_DLY; i++) begin
        own[i] <= 1'b0;
      end
    end else begin
      own[0] <= sel;
      for (int i = 1; i < `TCB_DLY; i++) begin
        own[i] <= own[i-1];
      end
    end
  end

  assign own_rsp = own[`TCB_DLY-1];

  // the other side sees zeros
  always_comb begin
    man0.rsp = '0;
    man1.rsp = '0;
    if (own_rsp) begin
      man1.rsp = sub.rsp;
    end else begin
      man0.rsp = sub.rsp;
    end
  end

  // one grant per cycle at most
  assert property (@(posedge tcb) disable iff (rst) !(gnt0 && gnt1));

endmodule: tcb_arbiter

`default_nettype wire

/* hw/tcb_riscv_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcb_defines.svh"

module tcb_riscv_align (
  input  logic                tcb,
  input  logic                rst,
  // risc-v load/store side
  input  logic                vld,
  output logic                rdy,
  input  logic                wen,
  input  logic [`TCB_AW-1:0]  adr,
  input  tcb_pkg::tcb_siz_t   siz,
  input  logic                uns,
  input  logic [`TCB_DW-1:0]  wdt,
  output logic [`TCB_DW-1:0]  rdt,
  output logic                sts,
  // byte-enable side
  tcb_if.man                  mem
);
  import tcb_pkg::*;

  // request info kept until the response
  typedef struct packed {
    logic [1:0] off;
    tcb_siz_t   siz;
    logic       uns;
    logic       mis;
  } stg_t;

  logic [1:0]         off;
  logic               mis;
  logic [3:0]         ben;
  logic [`TCB_DW-1:0] wdt_lane;
  stg_t               stg [0:`TCB_DLY-1];
  stg_t               stg_rsp;
  logic [`TCB_DW-1:0] lane;

  ////////////////////
  // request path
  ////////////////////

  assign off = adr[1:0];

  // enables and alignment check
  always_comb begin
    case (siz)
      TCB_SIZ_BYTE: begin
        ben = 4'b0001 << off;
        mis = 1'b0;
      end
      TCB_SIZ_HALF: begin
        ben = 4'b0011 << off;
        mis = off[0];
      end
      TCB_SIZ_WORD: begin
        ben = 4'b1111;
        mis = |off;
      end
      default: begin
        ben = 4'b0000;
        mis = 1'b1;
      end
    endcase
  end

  // replicate data into every lane
  always_comb begin
    case (siz)
      TCB_SIZ_BYTE: wdt_lane = {4{wdt[7:0]}};
      TCB_SIZ_HALF: wdt_lane = {2{wdt[15:0]}};
      default:      wdt_lane = wdt;
    endcase
  end

  // misaligned goes through with no lanes so nothing is written
  always_comb begin
    mem.vld     = vld;
    mem.req.wen = wen;
    mem.req.adr = {adr[`TCB_AW-1:2], 2'b00};
    mem.req.ben = mis ? 4'b0000 : ben;
    mem.req.wdt = wdt_lane;
  end

  assign rdy = mem.rdy;

  ////////////////////
  // delay stage
  ////////////////////

  always_ff @(posedge tcb) begin
    if (rst) begin
      for (int i = 0; i < `TCB_DLY; i++) begin
        stg[i] <= '0;
      end
    end else begin
      stg[0] <= '{off: off, siz: siz, uns: uns, mis: mis & mem.trn};
      for (int i = 1; i < `TCB_DLY; i++) begin
        stg[i] <= stg[i-1];
      end
    end
  end

  assign stg_rsp = stg[`TCB_DLY-1];

  ////////////////////
  // response path
  ////////////////////

  // selected lanes down to bit 0
  assign lane = mem.rsp.rdt >> {stg_rsp.off, 3'b000};

  // sign or zero extend
  always_comb begin
    case (stg_rsp.siz)
      TCB_SIZ_BYTE: rdt = {{24{lane[7] & ~stg_rsp.uns}}, lane[7:0]};
      TCB_SIZ_HALF: rdt = {{16{lane[15] & ~stg_rsp.uns}}, lane[15:0]};
      default:      rdt = lane;
    endcase
  end

  assign sts = mem.rsp.sts | stg_rsp.mis;

  // size 3 is not a legal access
  assert property (@(posedge tcb) disable iff (rst) vld |-> siz != 2'd3);

endmodule: tcb_riscv_align

`default_nettype wire

/* hw/tcb_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface tcb_if;
  import tcb_pkg::*;

  // handshake
  logic     vld;
  logic     rdy;

  // payload
  tcb_req_t req;
  tcb_rsp_t rsp;

  // transfer strobe, both sides look at it
  logic     trn;

  assign trn = vld & rdy;

  // requester side
  modport man (
    output vld,
    output req,
    input  rdy,
    input  rsp,
    input  trn
  );

  // responder side
  modport sub (
    input  vld,
    input  req,
    output rdy,
    output rsp,
    input  trn
  );

endinterface: tcb_if

`default_nettype wire

/* hw/tcb_pkg.sv */
`default_nettype none

`include "tcb_defines.svh"

package tcb_pkg;

  ////////////////////
  // transfer size
  ////////////////////

  // log2 of the number of bytes
  typedef logic [1:0] tcb_siz_t;

  localparam tcb_siz_t TCB_SIZ_BYTE = 2'd0;
  localparam tcb_siz_t TCB_SIZ_HALF = 2'd1;
  localparam tcb_siz_t TCB_SIZ_WORD = 2'd2;

  ////////////////////
  // request/response
  ////////////////////

  // byte-enable request, word aligned at the memory
  typedef struct packed {
    logic                   wen;
    logic [`TCB_AW-1:0]     adr;
    logic [`TCB_DW/8-1:0]   ben;
    logic [`TCB_DW-1:0]     wdt;
  } tcb_req_t;

  // response, sts high means error
  typedef struct packed {
    logic [`TCB_DW-1:0]     rdt;
    logic                   sts;
  } tcb_rsp_t;

endpackage: tcb_pkg

`default_nettype wire

/* hw/tcb_defines.svh */
`ifndef TCB_DEFINES_SVH
`define TCB_DEFINES_SVH

////////////////////
// bus geometry
////////////////////

// byte address width
`define TCB_AW 16

// data width, 4 byte lanes
`define TCB_DW 32

////////////////////
// memory
////////////////////

// depth in 32-bit words
`define TCB_MEM_WORDS 1024

// read delay in cycles
`define TCB_DLY 1

`endif
